// ==== dbg_wb_top.f ====
rtl/dbg_pkg.sv
rtl/dbg_burst_ctrl.sv
rtl/dbg_biu_tck.sv
rtl/dbg_biu_wb_master.sv
rtl/dbg_crc32.sv
rtl/dbg_wb_top.sv
tests/tb_wb_mem.sv
tests/tb_dbg_wb_top.sv

// ==== rtl/dbg_biu_tck.sv ====
/*
 * Bus interface unit, TCK domain stage
 * Decodes size and address into byte selects, moves write data
 * onto its lanes, latches the access and flips the start toggle.
 * Ready comes back as a toggle from the Wishbone domain
 */

module dbg_biu_tck import dbg_pkg::*; (
  input  logic      tck_i,
  input  logic      wb_rst,

  // From burst controller
  input  logic      biu_strb_i,
  input  logic      biu_rw_i,
  input  dbg_addr_t biu_addr_i,
  input  dbg_size_t biu_size_i,
  input  dbg_data_t biu_di_i,
  output logic      biu_rdy_o,

  // Clock crossing to WB stage
  input  logic      rdy_tgl_i,
  output logic      str_tgl_o,
  output dbg_sel_t  sel_o,
  output dbg_addr_t addr_o,
  output dbg_data_t wdata_o,
  output logic      we_o
);

  dbg_sel_t  be_dec;
  dbg_data_t di_swap;
  logic      start;

  // Ready toggle synchronizer
  logic      rdy_ff1;
  logic      rdy_ff2;
  logic      rdy_ff2q;

  assign start = biu_strb_i && biu_rdy_o;

  ////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////

  always_comb begin
    case (biu_size_i)
      3'd1: begin
        case (biu_addr_i[1:0])
          2'b00:   be_dec = DBG_LITTLE_ENDIAN ? 4'b0001 : 4'b1000;
          2'b01:   be_dec = DBG_LITTLE_ENDIAN ? 4'b0010 : 4'b0100;
          2'b10:   be_dec = DBG_LITTLE_ENDIAN ? 4'b0100 : 4'b0010;
          default: be_dec = DBG_LITTLE_ENDIAN ? 4'b1000 : 4'b0001;
        endcase
      end
      3'd2: begin
        if (!biu_addr_i[1]) begin
          be_dec = DBG_LITTLE_ENDIAN ? 4'b0011 : 4'b1100;
        end else begin
          be_dec = DBG_LITTLE_ENDIAN ? 4'b1100 : 4'b0011;
        end
      end
      // Word access
      default: be_dec = 4'b1111;
    endcase
  end

  // Short host words arrive in the high bits
  always_comb begin
    case (be_dec)
      4'b0001: di_swap = {24'h0, biu_di_i[31:24]};
      4'b0010: di_swap = {16'h0, biu_di_i[31:24], 8'h0};
      4'b0100: di_swap = {8'h0, biu_di_i[31:24], 16'h0};
      4'b1000: di_swap = {biu_di_i[31:24], 24'h0};
      4'b0011: di_swap = {16'h0, biu_di_i[31:16]};
      4'b1100: di_swap = {biu_di_i[31:16], 16'h0};
      default: di_swap = biu_di_i;
    endcase
  end

  ////////////////////////////////////////
  // Access latch and start toggle
  ////////////////////////////////////////

  // Held stable while the WB side runs the cycle
  always_ff @(posedge tck_i) begin
    if (start) begin
      sel_o  <= be_dec;
      addr_o <= biu_addr_i;
      we_o   <= ~biu_rw_i;
      if (!biu_rw_i) begin
        wdata_o <= di_swap;
      end
    end
  end

  always_ff @(posedge tck_i or posedge wb_rst) begin
    if (wb_rst) begin
      str_tgl_o <= 1'b0;
    end else if (start) begin
      str_tgl_o <= ~str_tgl_o;
    end
  end

  ////////////////////////////////////////
  // Ready return
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge wb_rst) begin
    if (wb_rst) begin
      rdy_ff1   <= 1'b0;
      rdy_ff2   <= 1'b0;
      rdy_ff2q  <= 1'b0;
      biu_rdy_o <= 1'b1;
    end else begin
      // Two sync flops plus edge flop
      rdy_ff1  <= rdy_tgl_i;
      rdy_ff2  <= rdy_ff1;
      rdy_ff2q <= rdy_ff2;
      if (start) begin
        biu_rdy_o <= 1'b0;
      end else if (rdy_ff2 != rdy_ff2q) begin
        biu_rdy_o <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/dbg_biu_wb_master.sv ====
/*
 * Bus interface unit, Wishbone domain stage
 * Synchronizes reset and the start toggle, runs one classic
 * single-access cycle per toggle and returns right-aligned read
 * data, the error flag and a response toggle
 */

module dbg_biu_wb_master import dbg_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      wb_rst,

  // Crossing from TCK stage
  input  logic      str_tgl_i,
  input  dbg_sel_t  sel_i,
  input  dbg_addr_t addr_i,
  input  dbg_data_t wdata_i,
  input  logic      we_i,
  output logic      rdy_tgl_o,
  output dbg_data_t rdata_o,
  output logic      err_o,

  // Wishbone master
  output logic      wb_cyc_o,
  output logic      wb_stb_o,
  output logic      wb_we_o,
  output dbg_addr_t wb_adr_o,
  output dbg_sel_t  wb_sel_o,
  output dbg_data_t wb_dat_o,
  output logic [2:0] wb_cti_o,
  output logic [1:0] wb_bte_o,
  input  dbg_data_t wb_dat_i,
  input  logic      wb_ack_i,
  input  logic      wb_err_i
);

  wb_state_t  state;

  // Local reset, released on wb_clk_i
  logic [1:0] rst_sync;
  logic       rst_wb;

  // Start toggle synchronizer
  logic       str_ff1;
  logic       str_ff2;
  logic       str_ff2q;
  logic       start;

  logic       resp;
  dbg_data_t  dat_swap;

  ////////////////////////////////////////
  // Synchronizers
  ////////////////////////////////////////

  // Asserts at once, releases after two edges
  always_ff @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      rst_sync <= 2'b11;
    end else begin
      rst_sync <= {rst_sync[0], 1'b0};
    end
  end

  assign rst_wb = rst_sync[1];

  always_ff @(posedge wb_clk_i or posedge rst_wb) begin
    if (rst_wb) begin
      str_ff1  <= 1'b0;
      str_ff2  <= 1'b0;
      str_ff2q <= 1'b0;
    end else begin
      str_ff1  <= str_tgl_i;
      str_ff2  <= str_ff1;
      str_ff2q <= str_ff2;
    end
  end

  // Any edge of the toggle is one access
  assign start = (str_ff2 != str_ff2q);

  ////////////////////////////////////////
  // Cycle state machine
  ////////////////////////////////////////

  // Ack or err ends the cycle
  assign resp = (state == WB_TRANSFER) && (wb_ack_i || wb_err_i);

  always_ff @(posedge wb_clk_i or posedge rst_wb) begin
    if (rst_wb) begin
      state    <= WB_IDLE;
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
    end else begin
      case (state)
        WB_IDLE: if (start) begin
          wb_cyc_o <= 1'b1;
          wb_stb_o <= 1'b1;
          state    <= WB_TRANSFER;
        end
        // Slave may stretch this without limit
        WB_TRANSFER: if (resp) begin
          wb_cyc_o <= 1'b0;
          wb_stb_o <= 1'b0;
          state    <= WB_IDLE;
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  // Selected lanes moved to the bottom, rest zero
  always_comb begin
    case (sel_i)
      4'b0001: dat_swap = {24'h0, wb_dat_i[7:0]};
      4'b0010: dat_swap = {24'h0, wb_dat_i[15:8]};
      4'b0100: dat_swap = {24'h0, wb_dat_i[23:16]};
      4'b1000: dat_swap = {24'h0, wb_dat_i[31:24]};
      4'b0011: dat_swap = {16'h0, wb_dat_i[15:0]};
      4'b1100: dat_swap = {16'h0, wb_dat_i[31:16]};
      default: dat_swap = wb_dat_i;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (resp) begin
      rdata_o <= dat_swap;
    end
  end

  // Error and toggle, read in TCK domain after sync
  always_ff @(posedge wb_clk_i or posedge rst_wb) begin
    if (rst_wb) begin
      err_o     <= 1'b0;
      rdy_tgl_o <= 1'b0;
    end else if (resp) begin
      err_o     <= wb_err_i;
      rdy_tgl_o <= ~rdy_tgl_o;
    end
  end

  // Request fields come straight from the TCK latch
  assign wb_we_o  = we_i;
  assign wb_adr_o = addr_i;
  assign wb_sel_o = sel_i;
  assign wb_dat_o = wdata_i;

  // Classic cycles only
  assign wb_cti_o = 3'b000;
  assign wb_bte_o = 2'b00;

endmodule

// ==== rtl/dbg_burst_ctrl.sv ====
/*
 * Burst controller, TCK domain
 * Accepts a burst command from the debug host and runs it as a
 * series of single bus accesses, stepping the address by the
 * access size, collecting a sticky error and feeding the CRC
 */

module dbg_burst_ctrl import dbg_pkg::*; (
  input  logic       tck_i,
  input  logic       wb_rst,

  // Host command
  input  logic       cmd_strb_i,
  input  logic       cmd_we_i,
  input  dbg_addr_t  cmd_addr_i,
  input  dbg_size_t  cmd_size_i,
  input  dbg_count_t cmd_count_i,

  // Host data and status
  input  logic       wdata_strb_i,
  input  dbg_data_t  wdata_i,
  output logic       busy_o,
  output logic       done_o,
  output logic       err_o,
  output logic       wdata_req_o,
  output dbg_data_t  rdata_o,
  output logic       rdata_vld_o,

  // Bus interface unit
  input  logic       biu_rdy_i,
  input  dbg_data_t  biu_do_i,
  input  logic       biu_err_i,
  output logic       biu_strb_o,
  output logic       biu_rw_o,
  output dbg_addr_t  biu_addr_o,
  output dbg_size_t  biu_size_o,
  output dbg_data_t  biu_di_o,

  // CRC stage
  output logic       crc_clr_o,
  output logic       crc_upd_o,
  output dbg_data_t  crc_data_o
);

  burst_state_t state;

  // Latched command
  logic         we_r;
  dbg_size_t    size_r;
  dbg_count_t   cnt_r;
  dbg_addr_t    addr_r;
  dbg_data_t    wdata_r;
  logic         err_r;

  logic         accept;
  logic         wdata_take;
  logic         resp;
  logic         last;
  dbg_size_t    size_norm;

  ////////////////////////////////////////
  // Handshake decode
  ////////////////////////////////////////

  // New command only while idle
  assign accept     = (state == BURST_IDLE) && cmd_strb_i;
  assign wdata_take = (state == BURST_WAIT_WDATA) && wdata_strb_i;
  // Ready back from the BIU ends one access
  assign resp       = (state == BURST_WAIT_RDY) && biu_rdy_i;
  assign last       = (cnt_r == dbg_count_t'(1));

  // Sizes other than byte or halfword run as words
  assign size_norm  = ((cmd_size_i == 3'd1) || (cmd_size_i == 3'd2)) ?
                      cmd_size_i : DBG_SIZE_WORD;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge wb_rst) begin
    if (wb_rst) begin
      state  <= BURST_IDLE;
      we_r   <= 1'b0;
      size_r <= DBG_SIZE_WORD;
      cnt_r  <= '0;
      err_r  <= 1'b0;
    end else begin
      case (state)
        BURST_IDLE: if (accept) begin
          we_r   <= cmd_we_i;
          size_r <= size_norm;
          // Zero count behaves as a single word
          cnt_r  <= (cmd_count_i == '0) ? dbg_count_t'(1) : cmd_count_i;
          err_r  <= 1'b0;
          state  <= cmd_we_i ? BURST_WAIT_WDATA : BURST_ISSUE;
        end
        BURST_WAIT_WDATA: if (wdata_strb_i) begin
          state <= BURST_ISSUE;
        end
        // Strobe goes out this cycle if the BIU is free
        BURST_ISSUE: if (biu_rdy_i) begin
          state <= BURST_WAIT_RDY;
        end
        BURST_WAIT_RDY: if (biu_rdy_i) begin
          // Errors accumulate, burst keeps going
          err_r <= err_r | biu_err_i;
          cnt_r <= cnt_r - dbg_count_t'(1);
          if (last) begin
            state <= BURST_DONE;
          end else if (we_r) begin
            state <= BURST_WAIT_WDATA;
          end else begin
            state <= BURST_ISSUE;
          end
        end
        BURST_DONE: state <= BURST_IDLE;
        default:    state <= BURST_IDLE;
      endcase
    end
  end

  // Address and write word
  always_ff @(posedge tck_i) begin
    if (accept) begin
      addr_r <= cmd_addr_i;
    end else if (resp) begin
      addr_r <= addr_r + dbg_addr_t'(size_r);
    end
    if (wdata_take) begin
      wdata_r <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign busy_o      = (state != BURST_IDLE);
  assign done_o      = (state == BURST_DONE);
  assign err_o       = err_r;
  assign wdata_req_o = (state == BURST_WAIT_WDATA);

  // Read word already right-aligned by the WB stage
  assign rdata_o     = biu_do_i;
  assign rdata_vld_o = resp && !we_r;

  assign biu_strb_o  = (state == BURST_ISSUE) && biu_rdy_i;
  assign biu_rw_o    = ~we_r;
  assign biu_addr_o  = addr_r;
  assign biu_size_o  = size_r;
  assign biu_di_o    = wdata_r;

  // CRC sees write words on accept, read words on return
  assign crc_clr_o   = accept;
  assign crc_upd_o   = wdata_take || (resp && !we_r);
  assign crc_data_o  = wdata_take ? wdata_i : biu_do_i;

endmodule

// ==== rtl/dbg_crc32.sv ====
/*
 * CRC-32 over the burst data stream
 * Reflected polynomial, one 32-bit word per cycle, LSB first
 */

module dbg_crc32 import dbg_pkg::*; (
  input  logic      tck_i,
  input  logic      wb_rst,
  input  logic      crc_clr_i,
  input  logic      crc_upd_i,
  input  dbg_data_t crc_data_i,
  output dbg_crc_t  crc_o
);

  dbg_crc_t crc_nxt;

  // 32 serial steps unrolled
  always_comb begin
    crc_nxt = crc_o;
    for (int i = 0; i < DBG_DATA_W; i++) begin
      if (crc_nxt[0] ^ crc_data_i[i]) begin
        crc_nxt = (crc_nxt >> 1) ^ DBG_CRC_POLY;
      end else begin
        crc_nxt = crc_nxt >> 1;
      end
    end
  end

  // Clear wins over update
  always_ff @(posedge tck_i or posedge wb_rst) begin
    if (wb_rst) begin
      crc_o <= DBG_CRC_INIT;
    end else if (crc_clr_i) begin
      crc_o <= DBG_CRC_INIT;
    end else if (crc_upd_i) begin
      crc_o <= crc_nxt;
    end
  end

endmodule

// ==== rtl/dbg_pkg.sv ====
/*
 * Debug unit Wishbone interface package
 * Shared widths, vector types, state encodings and CRC-32 constants
 * for the burst controller, bus interface stages and CRC stage
 */

package dbg_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int DBG_ADDR_W = 32;
  localparam int DBG_DATA_W = 32;

  // Bus address and data words
  typedef logic [DBG_ADDR_W-1:0]   dbg_addr_t;
  typedef logic [DBG_DATA_W-1:0]   dbg_data_t;

  // One select bit per byte lane
  typedef logic [DBG_DATA_W/8-1:0] dbg_sel_t;

  // Access size in bytes, 1, 2 or 4
  typedef logic [2:0]              dbg_size_t;

  // Words per burst, zero means one
  typedef logic [15:0]             dbg_count_t;

  typedef logic [31:0]             dbg_crc_t;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // Byte-lane order, little endian build only
  localparam bit        DBG_LITTLE_ENDIAN = 1'b1;

  // Full-word size, also used for illegal sizes
  localparam dbg_size_t DBG_SIZE_WORD     = 3'd4;

  // Reflected CRC-32 polynomial
  localparam dbg_crc_t  DBG_CRC_POLY      = 32'hEDB8_8320;
  // Start value, no final inversion
  localparam dbg_crc_t  DBG_CRC_INIT      = 32'hFFFF_FFFF;

  ////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////

  // Burst controller, TCK domain
  typedef enum logic [2:0] {
    BURST_IDLE,
    BURST_ISSUE,
    BURST_WAIT_RDY,
    BURST_WAIT_WDATA,
    BURST_DONE
  } burst_state_t;

  // Wishbone cycle, WB domain
  typedef enum logic {
    WB_IDLE,
    WB_TRANSFER
  } wb_state_t;

endpackage

// ==== rtl/dbg_wb_top.sv ====
/*
 * Debug unit Wishbone side, top level
 * Burst controller, TCK and Wishbone bus interface stages and
 * the CRC stage wired together
 */

module dbg_wb_top import dbg_pkg::*; (
  input  logic       tck_i,
  input  logic       wb_clk_i,
  input  logic       wb_rst,

  // Debug host
  input  logic       cmd_strb_i,
  input  logic       cmd_we_i,
  input  dbg_addr_t  cmd_addr_i,
  input  dbg_size_t  cmd_size_i,
  input  dbg_count_t cmd_count_i,
  input  logic       wdata_strb_i,
  input  dbg_data_t  wdata_i,
  output logic       busy_o,
  output logic       done_o,
  output logic       err_o,
  output logic       wdata_req_o,
  output dbg_data_t  rdata_o,
  output logic       rdata_vld_o,
  output dbg_crc_t   crc_o,

  // Wishbone master
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output logic       wb_we_o,
  output dbg_addr_t  wb_adr_o,
  output dbg_sel_t   wb_sel_o,
  output dbg_data_t  wb_dat_o,
  output logic [2:0] wb_cti_o,
  output logic [1:0] wb_bte_o,
  input  dbg_data_t  wb_dat_i,
  input  logic       wb_ack_i,
  input  logic       wb_err_i
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Controller to TCK stage
  logic      biu_strb;
  logic      biu_rw;
  dbg_addr_t biu_addr;
  dbg_size_t biu_size;
  dbg_data_t biu_di;
  logic      biu_rdy;

  // Clock crossing
  logic      str_tgl;
  dbg_sel_t  sel;
  dbg_addr_t addr;
  dbg_data_t wdata;
  logic      we;
  logic      rdy_tgl;
  dbg_data_t rdata;
  logic      err;

  // CRC tap
  logic      crc_clr;
  logic      crc_upd;
  dbg_data_t crc_data;

  dbg_burst_ctrl u_burst_ctrl (
    .tck_i        (tck_i),
    .wb_rst       (wb_rst),
    .cmd_strb_i   (cmd_strb_i),
    .cmd_we_i     (cmd_we_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_size_i   (cmd_size_i),
    .cmd_count_i  (cmd_count_i),
    .wdata_strb_i (wdata_strb_i),
    .wdata_i      (wdata_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .err_o        (err_o),
    .wdata_req_o  (wdata_req_o),
    .rdata_o      (rdata_o),
    .rdata_vld_o  (rdata_vld_o),
    .biu_rdy_i    (biu_rdy),
    .biu_do_i     (rdata),
    .biu_err_i    (err),
    .biu_strb_o   (biu_strb),
    .biu_rw_o     (biu_rw),
    .biu_addr_o   (biu_addr),
    .biu_size_o   (biu_size),
    .biu_di_o     (biu_di),
    .crc_clr_o    (crc_clr),
    .crc_upd_o    (crc_upd),
    .crc_data_o   (crc_data)
  );

  dbg_biu_tck u_biu_tck (
    .tck_i      (tck_i),
    .wb_rst     (wb_rst),
    .biu_strb_i (biu_strb),
    .biu_rw_i   (biu_rw),
    .biu_addr_i (biu_addr),
    .biu_size_i (biu_size),
    .biu_di_i   (biu_di),
    .biu_rdy_o  (biu_rdy),
    .rdy_tgl_i  (rdy_tgl),
    .str_tgl_o  (str_tgl),
    .sel_o      (sel),
    .addr_o     (addr),
    .wdata_o    (wdata),
    .we_o       (we)
  );

  dbg_biu_wb_master u_biu_wb_master (
    .wb_clk_i  (wb_clk_i),
    .wb_rst    (wb_rst),
    .str_tgl_i (str_tgl),
    .sel_i     (sel),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .we_i      (we),
    .rdy_tgl_o (rdy_tgl),
    .rdata_o   (rdata),
    .err_o     (err),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_we_o   (wb_we_o),
    .wb_adr_o  (wb_adr_o),
    .wb_sel_o  (wb_sel_o),
    .wb_dat_o  (wb_dat_o),
    .wb_cti_o  (wb_cti_o),
    .wb_bte_o  (wb_bte_o),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_i  (wb_ack_i),
    .wb_err_i  (wb_err_i)
  );

  dbg_crc32 u_crc32 (
    .tck_i      (tck_i),
    .wb_rst     (wb_rst),
    .crc_clr_i  (crc_clr),
    .crc_upd_i  (crc_upd),
    .crc_data_i (crc_data),
    .crc_o      (crc_o)
  );

endmodule

// ==== tests/tb_dbg_wb_top.sv ====
/*
 * Debug unit Wishbone side testbench
 * Drives burst commands from the host side against a slave memory
 * model and checks read data, CRC and error status against a
 * shadow memory and a CRC-32 reference
 */

module tb_dbg_wb_top import dbg_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic        tck_i;
  logic        wb_clk_i;
  logic        wb_rst;
  logic        cmd_strb_i;
  logic        cmd_we_i;
  dbg_addr_t   cmd_addr_i;
  dbg_size_t   cmd_size_i;
  dbg_count_t  cmd_count_i;
  logic        wdata_strb_i;
  dbg_data_t   wdata_i;
  logic        busy_o;
  logic        done_o;
  logic        err_o;
  logic        wdata_req_o;
  dbg_data_t   rdata_o;
  logic        rdata_vld_o;
  dbg_crc_t    crc_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  dbg_addr_t   wb_adr_o;
  dbg_sel_t    wb_sel_o;
  dbg_data_t   wb_dat_o;
  logic [2:0]  wb_cti_o;
  logic [1:0]  wb_bte_o;
  dbg_data_t   wb_dat_i;
  logic        wb_ack_i;
  logic        wb_err_i;

  logic [31:0] rand_state;
  // Expected memory contents, word indexed like the slave
  dbg_data_t   shadow [0:255];
  // Host write words for the next burst
  dbg_data_t   wbuf [0:15];

  dbg_wb_top u_dbg_wb_top (.*);

  tb_wb_mem u_mem (
    .wb_clk_i (wb_clk_i),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o),
    .wb_sel_i (wb_sel_o),
    .wb_dat_i (wb_dat_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack_o (wb_ack_i),
    .wb_err_o (wb_err_i)
  );

  initial begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;
  end

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  // Reflected CRC-32, word folded in first then 32 shifts
  function automatic dbg_crc_t crc_step(dbg_crc_t crc, dbg_data_t word);
    dbg_crc_t c;
    c = crc ^ word;
    for (int i = 0; i < 32; i++) begin
      c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    return c;
  endfunction

  // Sub-word host data sits in the top bits
  function automatic void shadow_write(dbg_addr_t a, dbg_size_t size, dbg_data_t d);
    case (size)
      3'd1:    shadow[a[9:2]][8*a[1:0] +: 8] = d[31:24];
      3'd2:    shadow[a[9:2]][16*a[1] +: 16] = d[31:16];
      default: shadow[a[9:2]] = d;
    endcase
  endfunction

  function automatic dbg_data_t shadow_read(dbg_addr_t a, dbg_size_t size);
    case (size)
      3'd1:    return {24'h0, shadow[a[9:2]][8*a[1:0] +: 8]};
      3'd2:    return {16'h0, shadow[a[9:2]][16*a[1] +: 16]};
      default: return shadow[a[9:2]];
    endcase
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("Done: errors found");
    $fatal(1, "%s", why);
  endtask

  task automatic check_data(input string name, input dbg_data_t exp, input dbg_data_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_run("read data differs from shadow memory");
    end
  endtask

  task automatic check_crc(input string name, input dbg_crc_t exp, input dbg_crc_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_run("burst CRC differs from reference");
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run("status flag has the wrong level");
    end
  endtask

  ////////////////////////////////////////
  // Host side
  ////////////////////////////////////////

  task automatic check_idle(input string name);
    @(negedge tck_i);
    check_flag({name, " busy_o"}, 1'b0, busy_o);
    check_flag({name, " wb_cyc_o"}, 1'b0, wb_cyc_o);
    check_flag({name, " wb_stb_o"}, 1'b0, wb_stb_o);
  endtask

  task automatic send_cmd(input bit we, input dbg_addr_t addr, input dbg_size_t size,
                          input dbg_count_t count);
    @(posedge tck_i);
    #2;
    cmd_strb_i  = 1'b1;
    cmd_we_i    = we;
    cmd_addr_i  = addr;
    cmd_size_i  = size;
    cmd_count_i = count;
    @(posedge tck_i);
    #2;
    cmd_strb_i  = 1'b0;
  endtask

  // Feeds write words, collects read words, ends on done_o
  task automatic run_burst(input string name, input bit we, input dbg_addr_t addr,
                           input dbg_size_t size, input int count, input bit exp_err);
    dbg_crc_t  crc_exp;
    dbg_data_t exp;
    dbg_addr_t a;
    int        sent;
    int        got;
    int        cycles;
    bit        done_seen;
    crc_exp   = DBG_CRC_INIT;
    a         = addr;
    sent      = 0;
    got       = 0;
    cycles    = 0;
    done_seen = 1'b0;
    check_idle(name);
    send_cmd(we, addr, size, dbg_count_t'(count));
    while (!done_seen) begin
      @(negedge tck_i);
      cycles++;
      if (cycles > 60 * count + 60) begin
        stop_run({"timeout waiting for done_o in ", name});
      end
      // Classic single cycles, no burst type
      check_flag({name, " wb_cti_o"}, 1'b0, |wb_cti_o);
      check_flag({name, " wb_bte_o"}, 1'b0, |wb_bte_o);
      if (wdata_req_o && sent < count) begin
        crc_exp = crc_step(crc_exp, wbuf[sent]);
        shadow_write(a, size, wbuf[sent]);
        a = a + size;
        @(posedge tck_i);
        #2;
        wdata_strb_i = 1'b1;
        wdata_i      = wbuf[sent];
        @(posedge tck_i);
        #2;
        wdata_strb_i = 1'b0;
        sent++;
      end else begin
        if (rdata_vld_o) begin
          // Error window words carry no data
          if (a < 32'h0000_F000) begin
            exp     = shadow_read(a, size);
            check_data(name, exp, rdata_o);
            crc_exp = crc_step(crc_exp, exp);
          end
          a = a + size;
          got++;
        end
        done_seen = done_o;
      end
    end
    if (got != (we ? 0 : count) || sent != (we ? count : 0)) begin
      stop_run({"wrong number of data words in ", name});
    end
    check_flag({name, " err_o"}, exp_err, err_o);
    if (!exp_err) begin
      check_crc(name, crc_exp, crc_o);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_idle();
    check_idle("reset_idle");
    check_flag("reset_idle done_o", 1'b0, done_o);
    check_flag("reset_idle wdata_req_o", 1'b0, wdata_req_o);
    check_flag("reset_idle rdata_vld_o", 1'b0, rdata_vld_o);
  endtask

  task automatic test_word_rw();
    wbuf[0] = rand_word();
    run_burst("word_write", 1'b1, 32'h0000_0040, 3'd4, 1, 1'b0);
    run_burst("word_read", 1'b0, 32'h0000_0040, 3'd4, 1, 1'b0);
  endtask

  task automatic test_sub_word();
    for (int i = 0; i < 4; i++) begin
      wbuf[i] = rand_word();
    end
    run_burst("sub_init", 1'b1, 32'h0000_0080, 3'd4, 4, 1'b0);
    // Offsets 3,0,1,2 across two words
    for (int i = 0; i < 4; i++) begin
      wbuf[i] = rand_word();
    end
    run_burst("byte_write", 1'b1, 32'h0000_0083, 3'd1, 4, 1'b0);
    // Upper half of one word, lower half of the next
    wbuf[0] = rand_word();
    wbuf[1] = rand_word();
    run_burst("half_write", 1'b1, 32'h0000_008A, 3'd2, 2, 1'b0);
    run_burst("word_readback", 1'b0, 32'h0000_0080, 3'd4, 4, 1'b0);
    run_burst("byte_readback", 1'b0, 32'h0000_0080, 3'd1, 16, 1'b0);
    run_burst("half_readback", 1'b0, 32'h0000_0080, 3'd2, 8, 1'b0);
  endtask

  // Eight words each way, CRC checked at both ends
  task automatic test_burst_crc();
    for (int i = 0; i < 8; i++) begin
      wbuf[i] = rand_word();
    end
    run_burst("burst_write", 1'b1, 32'h0000_0100, 3'd4, 8, 1'b0);
    run_burst("burst_read", 1'b0, 32'h0000_0100, 3'd4, 8, 1'b0);
  endtask

  task automatic test_err_window();
    wbuf[0] = rand_word();
    wbuf[1] = rand_word();
    run_burst("err_pre", 1'b1, 32'h0000_EFF8, 3'd4, 2, 1'b0);
    // Last two words fall into the error window
    run_burst("err_burst", 1'b0, 32'h0000_EFF8, 3'd4, 4, 1'b1);
    @(negedge tck_i);
    check_flag("err_closed wb_cyc_o", 1'b0, wb_cyc_o);
    check_flag("err_closed wb_stb_o", 1'b0, wb_stb_o);
    run_burst("err_recover", 1'b0, 32'h0000_0040, 3'd4, 1, 1'b0);
  endtask

  initial begin
    wb_rst       = 1'b1;
    cmd_strb_i   = 1'b0;
    cmd_we_i     = 1'b0;
    cmd_addr_i   = '0;
    cmd_size_i   = 3'd4;
    cmd_count_i  = '0;
    wdata_strb_i = 1'b0;
    wdata_i      = '0;
    rand_state   = 32'd14926;
    repeat (3) @(posedge wb_clk_i);
    #2;
    wb_rst = 1'b0;
    test_reset_idle();
    test_word_rw();
    test_sub_word();
    test_burst_crc();
    test_err_window();
    @(negedge tck_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tests/tb_wb_mem.sv ====
/*
 * Wishbone slave memory model
 * 256 words with byte selects, 0 to 3 random wait states per
 * cycle and an error response from address F000 hex upward
 */

module tb_wb_mem import dbg_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  dbg_addr_t wb_adr_i,
  input  dbg_sel_t  wb_sel_i,
  input  dbg_data_t wb_dat_i,
  output dbg_data_t wb_dat_o,
  output logic      wb_ack_o,
  output logic      wb_err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  dbg_data_t   mem [0:255];
  logic [31:0] lcg_state;
  logic [7:0]  idx;
  logic        in_cyc;
  int          wait_left;

  // Wait-state source
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  initial begin
    wb_dat_o  = '0;
    wb_ack_o  = 1'b0;
    wb_err_o  = 1'b0;
    lcg_state = 32'd14926;
    in_cyc    = 1'b0;
    wait_left = 0;
    // Fill pattern uses every bit of the word index
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'hA5, 8'(i), ~8'(i), 8'(i) + 8'h3C};
    end
    forever begin
      @(posedge wb_clk_i);
      #2;
      if (wb_ack_o || wb_err_o) begin
        // Master sampled the response on this edge
        wb_ack_o = 1'b0;
        wb_err_o = 1'b0;
        in_cyc   = 1'b0;
      end else if (wb_cyc_i && wb_stb_i) begin
        if (!in_cyc) begin
          in_cyc    = 1'b1;
          // Upper LCG bits, the low ones repeat too soon
          wait_left = int'((lcg_next() >> 16) % 4);
        end
        if (wait_left > 0) begin
          wait_left--;
        end else if (wb_adr_i >= 32'h0000_F000) begin
          wb_dat_o = '0;
          wb_err_o = 1'b1;
        end else begin
          idx = wb_adr_i[9:2];
          if (wb_we_i) begin
            for (int b = 0; b < 4; b++) begin
              if (wb_sel_i[b]) begin
                mem[idx][8*b +: 8] = wb_dat_i[8*b +: 8];
              end
            end
          end
          wb_dat_o = mem[idx];
          wb_ack_o = 1'b1;
        end
      end
    end
  end

endmodule
